// ==== design/mem_pkg.sv ====
// constants and types shared by the memory puzzle blocks
// presses are clean one-cycle strobes, already debounced
// button codes are one-hot; all zero means no press
package mem_pkg;

    localparam int num_stages = 5;  // stages per game
    localparam int num_pos    = 4;  // buttons, labels and digit values

    typedef logic [5:0] button_t;   // one-hot button code

    localparam button_t btn_none   = 6'b000000;
    localparam button_t btn_select = 6'b000001;
    localparam button_t btn_up     = 6'b000010;
    localparam button_t btn_right  = 6'b000100;
    localparam button_t btn_down   = 6'b001000;
    localparam button_t btn_left   = 6'b010000;
    localparam button_t btn_back   = 6'b100000;

    typedef enum logic [2:0] {
        menu     = 3'd0,  // waiting for a select to start
        scramble = 3'd1,  // generator filling a new puzzle
        play     = 3'd2,  // clock running, selects judged
        won      = 3'd3,
        lost     = 3'd4
    } game_state_t;

    // one press event
    typedef struct packed {
        logic    strobe;  // high for one cycle per press
        button_t button;  // which button
    } press_t;

    // what one stage shows, digit and labels all encoded 0..3
    typedef struct packed {
        logic [1:0]               digit;  // display digit minus one
        logic [num_pos-1:0][1:0]  label;  // label at each position, left is 0
    } stage_view_t;

    // whole generated puzzle
    typedef struct packed {
        stage_view_t [num_stages-1:0] stage_v;  // indexed by stage
    } puzzle_t;

endpackage

// ==== design/mem_game_fsm.sv ====
// game state machine, master of the four-phase generator request
// play starts the edge after gen_ack is seen low again
// timer_load and stage_reset are combinational one-cycle strobes
`timescale 1ns/1ps

module mem_game_fsm (
    input  logic                  clk,
    input  logic                  nrst,
    input  mem_pkg::press_t       press,
    input  logic                  mem_clear,    // detector: puzzle solved
    input  logic                  time_out,     // timer: clock at zero in play
    input  logic                  struck_out,   // timer: strikes at limit
    input  logic                  gen_ack,
    output mem_pkg::game_state_t  state,
    output logic                  gen_req,
    output logic                  timer_load,   // high in last scramble cycle
    output logic                  stage_reset   // high when the puzzle is handed over
);

    logic sel;      // select strobe
    logic in_scr;   // in scramble
    logic hs_done;  // both handshake lines back low

    assign sel     = press.strobe && (press.button == mem_pkg::btn_select);
    assign in_scr  = (state == mem_pkg::scramble);
    assign hs_done = !gen_req && !gen_ack;

    assign stage_reset = in_scr && gen_req && gen_ack;  // one cycle, then req drops
    assign timer_load  = in_scr && hs_done;            // same edge that enters play

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= mem_pkg::menu;
            gen_req <= 1'b0;
        end else begin
            case (state)
                mem_pkg::menu: begin
                    if (sel && !gen_ack) begin        // never raise req over a live ack
                        state   <= mem_pkg::scramble;
                        gen_req <= 1'b1;
                    end
                end
                mem_pkg::scramble: begin
                    if (gen_req && gen_ack) begin
                        gen_req <= 1'b0;              // phase 3
                    end else if (hs_done) begin
                        state <= mem_pkg::play;       // phase 4 seen
                    end
                end
                mem_pkg::play: begin
                    if (time_out || struck_out) begin
                        state <= mem_pkg::lost;       // losing wins a tie
                    end else if (mem_clear) begin
                        state <= mem_pkg::won;
                    end
                end
                mem_pkg::won, mem_pkg::lost: begin
                    if (sel) begin
                        state <= mem_pkg::menu;
                    end
                end
                default: begin
                    state   <= mem_pkg::menu;         // recover from an unused code
                    gen_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== design/mem_strike_timer.sv ====
// play clock and strike counter
// time_left loads time_limit on timer_load and counts down only in play
// strikes saturate at max_strikes and clear on the next timer_load
`timescale 1ns/1ps

module mem_strike_timer #(
    parameter int unsigned time_limit  = 600,
    parameter int unsigned max_strikes = 3
) (
    input  logic                              clk,
    input  logic                              nrst,
    input  mem_pkg::game_state_t              state,
    input  logic                              timer_load,
    input  logic                              mem_error,
    output logic [$clog2(time_limit+1)-1:0]   time_left,
    output logic [$clog2(max_strikes+1)-1:0]  strikes,
    output logic                              time_out,
    output logic                              struck_out
);

    localparam int tw = $clog2(time_limit + 1);   // timer width
    localparam int sw = $clog2(max_strikes + 1);  // strike counter width

    logic in_play;

    assign in_play    = (state == mem_pkg::play);
    assign time_out   = in_play && (time_left == '0);
    assign struck_out = (strikes >= sw'(max_strikes));  // fsm only looks in play

    always_ff @(posedge clk) begin
        if (!nrst) begin
            time_left <= '0;
            strikes   <= '0;
        end else begin
            if (timer_load) begin
                time_left <= tw'(time_limit);         // full time for the first play cycle
            end else if (in_play && time_left != '0) begin
                time_left <= time_left - 1'b1;
            end
            if (timer_load) begin
                strikes <= '0;                        // new game
            end else if (mem_error && strikes < sw'(max_strikes)) begin
                strikes <= strikes + 1'b1;
            end
        end
    end

endmodule

// ==== design/mem_puzzle_gen.sv ====
// puzzle generator, four-phase handshake slave
// gen_ack rises 6 cycles after gen_req is seen, one stage written per cycle
// gen_seed must be nonzero; the puzzle holds still outside the fill
`timescale 1ns/1ps

module mem_puzzle_gen #(
    parameter logic [15:0] gen_seed = 16'hace1
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              gen_req,
    output logic              gen_ack,
    output mem_pkg::puzzle_t  puzzle
);

    logic [15:0] lfsr;  // free running, time spent in menu stirs it
    logic        busy;  // filling stages
    logic [2:0]  idx;   // next stage to write, num_stages when done

    // digit from the low bits, labels by three swaps of the identity order
    function automatic mem_pkg::stage_view_t make_stage(input logic [15:0] r);
        mem_pkg::stage_view_t v;
        logic [1:0] a;
        logic [1:0] b;
        logic [1:0] tmp;
        v.digit = r[1:0];
        for (int i = 0; i < mem_pkg::num_pos; i++) begin
            v.label[i] = 2'(i);
        end
        for (int s = 0; s < 3; s++) begin
            a          = r[2 + 4*s +: 2];
            b          = r[4 + 4*s +: 2];
            tmp        = v.label[a];
            v.label[a] = v.label[b];        // a swap keeps it a permutation
            v.label[b] = tmp;
        end
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr    <= gen_seed;
            busy    <= 1'b0;
            idx     <= '0;
            gen_ack <= 1'b0;
        end else begin
            // galois form, x^16 + x^14 + x^13 + x^11 + 1
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            if (!busy && !gen_ack && gen_req) begin
                busy <= 1'b1;                 // request seen
                idx  <= '0;
            end else if (busy) begin
                if (idx < 3'(mem_pkg::num_stages)) begin
                    idx <= idx + 3'd1;
                end else begin
                    busy    <= 1'b0;
                    gen_ack <= 1'b1;          // phase 2
                end
            end else if (gen_ack && !gen_req) begin
                gen_ack <= 1'b0;              // phase 4
            end
        end
    end

    // payload only, written during the fill
    always_ff @(posedge clk) begin
        if (busy && idx < 3'(mem_pkg::num_stages)) begin
            puzzle.stage_v[idx] <= make_stage(lfsr);
        end
    end

endmodule

// ==== design/mem_cursor.sv ====
// selected position, wraps modulo 4
// moves only in play, held at 0 through scramble
`timescale 1ns/1ps

module mem_cursor (
    input  logic                  clk,
    input  logic                  nrst,
    input  mem_pkg::press_t       press,
    input  mem_pkg::game_state_t  state,
    output logic [1:0]            mem_pos
);

    logic go_right;  // right press in play
    logic go_left;   // left press in play

    assign go_right = press.strobe && (press.button == mem_pkg::btn_right)
                      && (state == mem_pkg::play);
    assign go_left  = press.strobe && (press.button == mem_pkg::btn_left)
                      && (state == mem_pkg::play);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mem_pos <= 2'd0;
        end else if (state == mem_pkg::scramble) begin
            mem_pos <= 2'd0;            // every new game starts leftmost
        end else if (go_right) begin
            mem_pos <= mem_pos + 2'd1;  // 3 wraps to 0
        end else if (go_left) begin
            mem_pos <= mem_pos - 2'd1;  // 0 wraps to 3
        end
    end

endmodule

// ==== design/mem_select_detector.sv ====
// judges select presses against the memory stage rules
// mem_clear and mem_error are combinational, in the cycle of the press
// stage stays at 4 once the puzzle is cleared, until stage_reset
`timescale 1ns/1ps

module mem_select_detector (
    input  logic                  clk,
    input  logic                  nrst,
    input  mem_pkg::game_state_t  state,
    input  logic                  stage_reset,
    input  mem_pkg::press_t       press,
    input  mem_pkg::puzzle_t      puzzle,
    input  logic [1:0]            mem_pos,
    output logic                  mem_error,
    output logic                  mem_clear,
    output logic [2:0]            stage
);

    localparam logic [2:0] last_stage = 3'(mem_pkg::num_stages - 1);

    mem_pkg::stage_view_t [mem_pkg::num_stages-1:0] sv;  // short alias of the puzzle
    logic [mem_pkg::num_stages-1:0][1:0] right_pos;      // correct position per stage
    logic [mem_pkg::num_stages-2:0][1:0] right_lab;      // label pressed, stages 0..3
    logic sel;  // select in play
    logic hit;  // cursor on the right position

    // position that shows a given label, labels are a permutation so one matches
    function automatic logic [1:0] pos_of(input mem_pkg::stage_view_t v,
                                          input logic [1:0] lab);
        logic [1:0] p;
        p = 2'd0;
        for (int i = 0; i < mem_pkg::num_pos; i++) begin
            if (v.label[i] == lab) begin
                p = 2'(i);
            end
        end
        return p;
    endfunction

    assign sv = puzzle.stage_v;

    // rule table, digit 0..3 stands for display 1..4
    always_comb begin
        right_pos = '0;
        right_lab = '0;
        case (sv[0].digit)
            2'd0, 2'd1: right_pos[0] = 2'd1;            // second position
            2'd2:       right_pos[0] = 2'd2;            // third position
            default:    right_pos[0] = 2'd3;            // fourth position
        endcase
        right_lab[0] = sv[0].label[right_pos[0]];

        case (sv[1].digit)
            2'd0:       right_pos[1] = pos_of(sv[1], 2'd3);  // the label 4
            2'd2:       right_pos[1] = 2'd0;                 // first position
            default:    right_pos[1] = right_pos[0];         // same position as stage 1
        endcase
        right_lab[1] = sv[1].label[right_pos[1]];

        case (sv[2].digit)
            2'd0:       right_pos[2] = pos_of(sv[2], right_lab[1]);  // label of stage 2
            2'd1:       right_pos[2] = pos_of(sv[2], right_lab[0]);  // label of stage 1
            2'd2:       right_pos[2] = 2'd2;                         // third position
            default:    right_pos[2] = pos_of(sv[2], 2'd3);          // the label 4
        endcase
        right_lab[2] = sv[2].label[right_pos[2]];

        case (sv[3].digit)
            2'd0:       right_pos[3] = right_pos[0];    // position of stage 1
            2'd1:       right_pos[3] = 2'd0;            // first position
            default:    right_pos[3] = right_pos[1];    // position of stage 2
        endcase
        right_lab[3] = sv[3].label[right_pos[3]];

        case (sv[4].digit)
            2'd0:       right_pos[4] = pos_of(sv[4], right_lab[0]);  // label of stage 1
            2'd1:       right_pos[4] = pos_of(sv[4], right_lab[1]);  // label of stage 2
            2'd2:       right_pos[4] = pos_of(sv[4], right_lab[3]);  // label of stage 4
            default:    right_pos[4] = pos_of(sv[4], right_lab[2]);  // label of stage 3
        endcase
    end

    assign sel = press.strobe && (press.button == mem_pkg::btn_select)
                 && (state == mem_pkg::play);
    assign hit = (mem_pos == right_pos[stage]);  // stage never passes 4

    assign mem_clear = sel && hit && (stage == last_stage);
    assign mem_error = sel && !hit;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            stage <= 3'd0;
        end else if (stage_reset) begin
            stage <= 3'd0;                // fresh puzzle
        end else if (sel && hit && stage != last_stage) begin
            stage <= stage + 3'd1;
        end
    end

endmodule

// ==== design/mem_puzzle_top.sv ====
// memory puzzle top level, the only bomb module kept
// gen_seed must be nonzero or the LFSR locks up
// time_left and strikes widths follow time_limit and max_strikes
`timescale 1ns/1ps

module mem_puzzle_top #(
    parameter int unsigned time_limit  = 600,       // play cycles allowed
    parameter int unsigned max_strikes = 3,         // errors that lose the game
    parameter logic [15:0] gen_seed    = 16'hace1   // LFSR start value
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  mem_pkg::press_t                    press,      // button strobe
    output mem_pkg::game_state_t               state,
    output logic [2:0]                         stage,      // current stage 0..4
    output mem_pkg::stage_view_t               view,       // digit and labels shown now
    output logic [1:0]                         mem_pos,    // selected position
    output logic [$clog2(max_strikes+1)-1:0]   strikes,
    output logic [$clog2(time_limit+1)-1:0]    time_left
);

    logic              gen_req;      // fsm asks for a new puzzle
    logic              gen_ack;      // generator done
    logic              mem_clear;    // last stage solved
    logic              mem_error;    // wrong select
    logic              time_out;     // clock ran out
    logic              struck_out;   // too many strikes
    logic              timer_load;   // first play cycle follows
    logic              stage_reset;  // restart at stage 0
    mem_pkg::puzzle_t  puzzle;       // all five stages

    assign view = puzzle.stage_v[stage];  // stage never passes 4

    mem_game_fsm i_fsm (
        .clk         (clk),
        .nrst        (nrst),
        .press       (press),
        .mem_clear   (mem_clear),
        .time_out    (time_out),
        .struck_out  (struck_out),
        .gen_ack     (gen_ack),
        .state       (state),
        .gen_req     (gen_req),
        .timer_load  (timer_load),
        .stage_reset (stage_reset)
    );

    mem_strike_timer #(
        .time_limit  (time_limit),
        .max_strikes (max_strikes)
    ) i_timer (
        .clk         (clk),
        .nrst        (nrst),
        .state       (state),
        .timer_load  (timer_load),
        .mem_error   (mem_error),
        .time_left   (time_left),
        .strikes     (strikes),
        .time_out    (time_out),
        .struck_out  (struck_out)
    );

    mem_puzzle_gen #(.gen_seed(gen_seed)) i_gen (
        .clk     (clk),
        .nrst    (nrst),
        .gen_req (gen_req),
        .gen_ack (gen_ack),
        .puzzle  (puzzle)
    );

    mem_cursor i_cursor (
        .clk     (clk),
        .nrst    (nrst),
        .press   (press),
        .state   (state),
        .mem_pos (mem_pos)
    );

    mem_select_detector i_detector (
        .clk         (clk),
        .nrst        (nrst),
        .state       (state),
        .stage_reset (stage_reset),
        .press       (press),
        .puzzle      (puzzle),
        .mem_pos     (mem_pos),
        .mem_error   (mem_error),
        .mem_clear   (mem_clear),
        .stage       (stage)
    );

endmodule

// ==== bench/mem_puzzle_props.sv ====
// concurrent checks on the generator handshake, the judge strobes and strikes
// bound into every mem_puzzle_top, reads its internal nets only
`timescale 1ns/1ps

module mem_puzzle_props #(
    parameter int unsigned max_strikes = 3
) (
    input logic                              clk,
    input logic                              nrst,
    input logic                              gen_req,
    input logic                              gen_ack,
    input logic                              mem_clear,
    input logic                              mem_error,
    input logic [$clog2(max_strikes+1)-1:0]  strikes
);

    req_after_ack_low: assert property (@(posedge clk) disable iff (!nrst)
        $rose(gen_req) |-> !gen_ack)  // phase 1 only from idle
        else $error("gen_req rose while gen_ack was high");

    ack_under_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(gen_ack) |-> gen_req)   // phase 2 answers a live request
        else $error("gen_ack rose without gen_req");

    clear_error_apart: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_clear && mem_error))
        else $error("mem_clear and mem_error high together");

    strikes_capped: assert property (@(posedge clk) disable iff (!nrst)
        strikes <= max_strikes)       // counter saturates
        else $error("strikes above max_strikes");

endmodule

bind mem_puzzle_top mem_puzzle_props #(.max_strikes(max_strikes)) i_props (
    .clk       (clk),
    .nrst      (nrst),
    .gen_req   (gen_req),
    .gen_ack   (gen_ack),
    .mem_clear (mem_clear),
    .mem_error (mem_error),
    .strikes   (strikes)
);

// ==== bench/mem_puzzle_tb.sv ====
// memory puzzle testbench, xorshift stimulus checked against a rule model
// inputs change 5 ns after the rising edge, outputs read at the same point
// DUT runs with time_limit 600 and max_strikes 3
`timescale 1ns/1ps

module mem_puzzle_tb;

    localparam int unsigned time_limit  = 600;
    localparam int unsigned max_strikes = 3;
    localparam int          num_wins    = 3;                            // solved puzzles
    localparam longint      watchdog_ns = 6 * (time_limit + 50) * 100;  // 6 games

    logic                                clk;
    logic                                nrst;
    mem_pkg::press_t                     press;
    mem_pkg::game_state_t                state;
    logic [2:0]                          stage;
    mem_pkg::stage_view_t                view;
    logic [1:0]                          mem_pos;
    logic [$clog2(max_strikes+1)-1:0]    strikes;
    logic [$clog2(time_limit+1)-1:0]     time_left;

    logic [31:0] rng;             // xorshift state
    int          errors;          // failed checks so far
    int          err_mark;        // errors when the current test began
    int          tests_run;
    int          tests_bad;
    logic [1:0]  model_pos;       // where the cursor should be
    int          model_strikes;
    logic [1:0]  hist_pos [5];    // correct position of each solved stage
    logic [1:0]  hist_lab [5];    // label pressed there

    mem_puzzle_top #(
        .time_limit  (time_limit),
        .max_strikes (max_strikes)
    ) i_mem_puzzle_top (
        .clk       (clk),
        .nrst      (nrst),
        .press     (press),
        .state     (state),
        .stage     (stage),
        .view      (view),
        .mem_pos   (mem_pos),
        .strikes   (strikes),
        .time_left (time_left)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory rules, digit 0..3 means display 1..4, label 3 means "4"
    function automatic logic [1:0] answer(input int k, input mem_pkg::stage_view_t v);
        int         want_lab;  // label to find, -1 when the position is fixed
        logic [1:0] p;
        want_lab = -1;
        p        = 2'd0;
        case (k)
            0: p = (v.digit == 2'd3) ? 2'd3 : (v.digit == 2'd2) ? 2'd2 : 2'd1;
            1: begin
                want_lab = (v.digit == 2'd0) ? 3 : -1;
                p        = (v.digit == 2'd2) ? 2'd0 : hist_pos[0];
            end
            2: begin
                case (v.digit)
                    2'd0:    want_lab = int'(hist_lab[1]);
                    2'd1:    want_lab = int'(hist_lab[0]);
                    2'd2:    p = 2'd2;
                    default: want_lab = 3;
                endcase
            end
            3: p = (v.digit == 2'd0) ? hist_pos[0] : (v.digit == 2'd1) ? 2'd0 : hist_pos[1];
            default: begin
                case (v.digit)
                    2'd0:    want_lab = int'(hist_lab[0]);
                    2'd1:    want_lab = int'(hist_lab[1]);
                    2'd2:    want_lab = int'(hist_lab[3]);
                    default: want_lab = int'(hist_lab[2]);
                endcase
            end
        endcase
        if (want_lab >= 0) begin
            for (int i = 0; i < 4; i++) begin
                if (v.label[i] == 2'(want_lab)) p = 2'(i);
            end
        end
        return p;
    endfunction

    task automatic check(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("FAILED at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic push(input mem_pkg::button_t b);  // one-cycle strobe
        press.strobe = 1'b1;
        press.button = b;
        tick();
        press = '0;
    endtask

    task automatic wait_state(input mem_pkg::game_state_t want, input int max_cycles);
        int n;
        n = 0;
        while (state != want && n < max_cycles) begin
            tick();
            n++;
        end
        assert (state == want) else begin
            $display("ERROR at time %0t: state %0d not reached in %0d cycles",
                     $time, want, max_cycles);
            errors++;
        end
    endtask

    task automatic start_game();
        int idle;
        rng  = xorshift32(rng);
        idle = int'(rng[2:0]);  // time in menu stirs the generator
        repeat (idle) tick();
        check("state", mem_pkg::menu, state);
        push(mem_pkg::btn_select);
        wait_state(mem_pkg::play, 20);
        check("time_left", time_limit, time_left);
        check("stage", 0, stage);
        check("mem_pos", 0, mem_pos);
        check("strikes", 0, strikes);
        model_pos     = 2'd0;
        model_strikes = 0;
    endtask

    task automatic steer(input logic [1:0] target);  // random walk onto target
        while (model_pos != target) begin
            rng = xorshift32(rng);
            if (rng[0]) begin
                push(mem_pkg::btn_right);
                model_pos = model_pos + 2'd1;
            end else begin
                push(mem_pkg::btn_left);
                model_pos = model_pos - 2'd1;
            end
            check("mem_pos", model_pos, mem_pos);
        end
    endtask

    task automatic check_view();  // labels must be a permutation of 0..3
        logic [3:0] seen;
        seen = 4'b0000;
        for (int i = 0; i < 4; i++) begin
            seen[view.label[i]] = 1'b1;
        end
        check("view.label set", 4'hf, seen);
    endtask

    task automatic select_right(input int k);
        logic [1:0] p;
        check_view();
        p           = answer(k, view);
        hist_pos[k] = p;
        hist_lab[k] = view.label[p];
        steer(p);
        push(mem_pkg::btn_select);
        check("stage", (k < 4) ? k + 1 : 4, stage);
        check("state", (k < 4) ? mem_pkg::play : mem_pkg::won, state);
    endtask

    task automatic select_wrong(input int k);
        logic [1:0] p;
        check_view();
        rng = xorshift32(rng);
        p   = answer(k, view) + 2'(1 + rng[7:0] % 3);  // never the right one
        steer(p);
        push(mem_pkg::btn_select);
        model_strikes++;
        check("stage", k, stage);
        check("strikes", model_strikes, strikes);
        check("state", mem_pkg::play, state);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("[ok]   %s", name);
        end else begin
            tests_bad++;
            $display("[FAIL] %s, %0d checks failed", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int first;
        press     = '0;
        nrst      = 1'b0;
        rng       = 32'h03bf1802;
        errors    = 0;
        err_mark  = 0;
        tests_run = 0;
        tests_bad = 0;
        model_pos = 2'd0;
        repeat (4) @(posedge clk);
        #5;
        nrst = 1'b1;
        check("state", mem_pkg::menu, state);
        check("stage", 0, stage);
        check("mem_pos", 0, mem_pos);
        check("strikes", 0, strikes);
        check("time_left", 0, time_left);
        start_game();
        finish_test("reset");

        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            steer(rng[9:8]);  // wanders both ways across the wrap
        end
        finish_test("cursor");

        for (int g = 0; g < num_wins; g++) begin
            if (g > 0) start_game();
            for (int k = 0; k < 5; k++) begin
                select_right(k);
            end
            push(mem_pkg::btn_select);
            check("state", mem_pkg::menu, state);
        end
        finish_test("winning");

        start_game();
        rng   = xorshift32(rng);
        first = int'(rng[3:0] % 3);  // stages solved before the mistakes
        for (int k = 0; k < first; k++) begin
            select_right(k);
        end
        for (int s = 0; s < max_strikes; s++) begin
            select_wrong(first);
        end
        push(mem_pkg::btn_select);  // one more miss in the last play cycle
        check("strikes", max_strikes, strikes);
        check("state", mem_pkg::lost, state);
        push(mem_pkg::btn_select);
        check("state", mem_pkg::menu, state);
        finish_test("strikes");

        start_game();
        for (int t = time_limit; t >= 0; t--) begin
            check("time_left", t, time_left);
            check("state", mem_pkg::play, state);
            tick();
        end
        check("state", mem_pkg::lost, state);  // one cycle after zero
        push(mem_pkg::btn_select);
        check("state", mem_pkg::menu, state);
        finish_test("timeout");

        $display("%0d tests, %0d with errors, %0d checks failed", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("ERROR: watchdog expired before the last test finished");
        $display("test failed");
        $finish;
    end

endmodule

// ==== mem_puzzle.f ====
design/mem_pkg.sv
design/mem_game_fsm.sv
design/mem_strike_timer.sv
design/mem_puzzle_gen.sv
design/mem_cursor.sv
design/mem_select_detector.sv
design/mem_puzzle_top.sv
bench/mem_puzzle_props.sv
bench/mem_puzzle_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory puzzle testbench with Verilator, run it, and judge the log.
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_puzzle_tb -f mem_puzzle.f \
    --Mdir "$build_dir" -o mem_puzzle_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"./$build_dir/mem_puzzle_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$log"; then
    exit 0
fi
echo "run_sim: pass line not found in $log"
exit 1
